// ==== Makefile ====
# Verilator simulation of the WISC core testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== cpu.f ====
src/cpu_pkg.sv
src/control_unit.sv
src/register_file.sv
src/alu.sv
src/pc_control.sv
src/cpu.sv
tests/clock_gen.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

// ==== src/alu.sv ====
// Arithmetic unit of the WISC core
// Saturating add/sub, XOR, shifts, rotate, nibble-wise saturating
// add, plus the plain adder and byte merge used by memory and LLB/LHB
`default_nettype none

module alu (
    input  cpu_pkg::opcode_t op,
    input  cpu_pkg::word_t   operand_a,
    input  cpu_pkg::word_t   operand_b,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flags_t  flags
);

    cpu_pkg::word_t add_raw;
    cpu_pkg::word_t sub_raw;
    cpu_pkg::word_t add_sat;
    cpu_pkg::word_t sub_sat;
    cpu_pkg::word_t paddsb_res;
    logic           add_ovf;
    logic           sub_ovf;
    logic           ovf;
    logic [3:0]     amt;
    logic [31:0]    rot_full;

    // Signed 4-bit add clamped to -8..7
    function automatic logic [3:0] sat_nibble(input logic [3:0] x, input logic [3:0] y);
        logic [3:0] s;
        s = x + y;
        if ((x[3] == y[3]) && (s[3] != x[3])) begin
            s = x[3] ? 4'h8 : 4'h7;
        end
        return s;
    endfunction

    // ---------------------------------------------------------------------
    // Adder paths
    // ---------------------------------------------------------------------
    assign add_raw = operand_a + operand_b;
    assign sub_raw = operand_a - operand_b;

    // Overflow when the result sign disagrees with operand_a's
    assign add_ovf = (operand_a[15] == operand_b[15]) && (add_raw[15] != operand_a[15]);
    assign sub_ovf = (operand_a[15] != operand_b[15]) && (sub_raw[15] != operand_a[15]);

    assign add_sat = add_ovf ? (operand_a[15] ? cpu_pkg::SAT_NEG : cpu_pkg::SAT_POS) : add_raw;
    assign sub_sat = sub_ovf ? (operand_a[15] ? cpu_pkg::SAT_NEG : cpu_pkg::SAT_POS) : sub_raw;

    for (genvar i = 0; i < 4; i++) begin : g_nibble
        assign paddsb_res[4*i +: 4] = sat_nibble(operand_a[4*i +: 4], operand_b[4*i +: 4]);
    end

    // Shifter, only the low 4 bits count
    assign amt      = operand_b[3:0];
    assign rot_full = {operand_a, operand_a} >> amt;

    // ---------------------------------------------------------------------
    // Result select
    // ---------------------------------------------------------------------
    always_comb begin
        ovf = 1'b0;
        case (op)
            cpu_pkg::OP_ADD: begin
                result = add_sat;
                ovf    = add_ovf;
            end
            cpu_pkg::OP_SUB: begin
                result = sub_sat;
                ovf    = sub_ovf;
            end
            cpu_pkg::OP_XOR:    result = operand_a ^ operand_b;
            cpu_pkg::OP_SLL:    result = operand_a << amt;
            cpu_pkg::OP_SRA:    result = cpu_pkg::word_t'($signed(operand_a) >>> amt);
            cpu_pkg::OP_ROR:    result = rot_full[15:0];
            cpu_pkg::OP_PADDSB: result = paddsb_res;
            // Effective address, no saturation
            cpu_pkg::OP_LW, cpu_pkg::OP_SW: result = add_raw;
            // Byte merge, operands arrive already masked
            cpu_pkg::OP_LLB, cpu_pkg::OP_LHB: result = operand_a | operand_b;
            default:            result = '0;
        endcase
    end

    assign flags = '{zero: (result == '0), overflow: ovf, negative: result[15]};

endmodule

`default_nettype wire

// ==== src/control_unit.sv ====
// Main decoder of the WISC core
// Turns the opcode into the control bundle for datapath,
// flag register and PC logic
`default_nettype none

module control_unit (
    input  cpu_pkg::opcode_t opcode,
    output cpu_pkg::ctrl_t   ctrl
);

    always_comb begin
        // Everything inactive unless the opcode asks for it
        ctrl = '0;
        case (opcode)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
                ctrl.reg_write = 1'b1;
                ctrl.flag_en   = cpu_pkg::FLAG_EN_ALL;
            end
            cpu_pkg::OP_XOR: begin
                ctrl.reg_write = 1'b1;
                ctrl.flag_en   = cpu_pkg::FLAG_EN_ZERO;
            end
            // Shift amount comes from the immediate field
            cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.flag_en     = cpu_pkg::FLAG_EN_ZERO;
            end
            cpu_pkg::OP_PADDSB: begin
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            // Byte loads read rd as source 1 and merge into it
            cpu_pkg::OP_LLB: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.llb         = 1'b1;
            end
            cpu_pkg::OP_LHB: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.lhb         = 1'b1;
            end
            cpu_pkg::OP_B: begin
                ctrl.branch = 1'b1;
            end
            cpu_pkg::OP_BR: begin
                ctrl.branch_reg = 1'b1;
            end
            cpu_pkg::OP_PCS: begin
                ctrl.reg_write = 1'b1;
                ctrl.pcs       = 1'b1;
            end
            cpu_pkg::OP_HLT: begin
                ctrl.halt = 1'b1;
            end
            // RED is not implemented and falls through as a no-op
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
// Single-cycle WISC core, top level
// Field split, operand and immediate select, address forming and
// write-back; instruction and data memories sit outside the core
`default_nettype none

module cpu (
    input  logic           clk,
    input  logic           reset,
    output cpu_pkg::word_t instr_addr,
    input  cpu_pkg::word_t instr,
    output cpu_pkg::word_t mem_addr,
    output cpu_pkg::word_t mem_wdata,
    output logic           mem_we,
    input  cpu_pkg::word_t mem_rdata,
    output cpu_pkg::word_t pc,
    output logic           hlt
);

    cpu_pkg::opcode_t   opcode;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t src1_addr;
    cpu_pkg::reg_addr_t src2_addr;
    cpu_pkg::ctrl_t     ctrl;
    cpu_pkg::word_t     read_data1;
    cpu_pkg::word_t     read_data2;
    cpu_pkg::word_t     imm_value;
    cpu_pkg::word_t     operand_a;
    cpu_pkg::word_t     operand_b;
    cpu_pkg::word_t     alu_result;
    cpu_pkg::flags_t    alu_flags;
    cpu_pkg::word_t     branch_offset;
    cpu_pkg::word_t     pc_plus_two;
    cpu_pkg::word_t     write_data;
    logic               mem_access;
    logic               reg_write_en;
    logic               halted;

    // ---------------------------------------------------------------------
    // Fetch and decode
    // ---------------------------------------------------------------------
    assign instr_addr = pc;

    assign opcode = cpu_pkg::opcode_t'(instr[15:12]);
    assign rd     = instr[11:8];
    assign rs     = instr[7:4];
    assign rt     = instr[3:0];

    control_unit u_control_unit (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    // LLB/LHB merge into rd, SW stores rd
    assign src1_addr = (ctrl.llb || ctrl.lhb) ? rd : rs;
    assign src2_addr = ctrl.mem_write ? rd : rt;

    register_file u_register_file (
        .clk        (clk),
        .reset      (reset),
        .read_addr1 (src1_addr),
        .read_addr2 (src2_addr),
        .write_addr (rd),
        .write_en   (reg_write_en),
        .write_data (write_data),
        .read_data1 (read_data1),
        .read_data2 (read_data2)
    );

    // ---------------------------------------------------------------------
    // Operands
    // ---------------------------------------------------------------------
    assign mem_access = ctrl.mem_read | ctrl.mem_write;

    always_comb begin
        if (mem_access) begin
            // Signed word offset
            imm_value = {{11{instr[3]}}, instr[3:0], 1'b0};
            operand_a = read_data1 & cpu_pkg::ADDR_ALIGN_MASK;
        end else if (ctrl.llb) begin
            imm_value = {8'h00, instr[7:0]};
            operand_a = read_data1 & cpu_pkg::LLB_KEEP_MASK;
        end else if (ctrl.lhb) begin
            imm_value = {instr[7:0], 8'h00};
            operand_a = read_data1 & cpu_pkg::LHB_KEEP_MASK;
        end else begin
            // Shift amount
            imm_value = {12'h000, instr[3:0]};
            operand_a = read_data1;
        end
    end

    assign operand_b = ctrl.alu_src_imm ? imm_value : read_data2;

    alu u_alu (
        .op        (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (alu_result),
        .flags     (alu_flags)
    );

    // ---------------------------------------------------------------------
    // PC, flags and halt
    // ---------------------------------------------------------------------
    assign branch_offset = {{6{instr[8]}}, instr[8:0], 1'b0};

    pc_control u_pc_control (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl),
        .cond          (cpu_pkg::cond_t'(instr[11:9])),
        .branch_offset (branch_offset),
        .branch_target (read_data1),
        .new_flags     (alu_flags),
        .pc            (pc),
        .pc_plus_two   (pc_plus_two),
        .halted        (halted)
    );

    assign hlt = halted;

    // ---------------------------------------------------------------------
    // Memory and write-back
    // ---------------------------------------------------------------------
    assign mem_addr  = alu_result;
    assign mem_wdata = read_data2;
    assign mem_we    = ctrl.mem_write & ~reset & ~halted;

    assign write_data = ctrl.pcs        ? pc_plus_two :
                        ctrl.mem_to_reg ? mem_rdata   :
                                          alu_result;

    assign reg_write_en = ctrl.reg_write & ~reset & ~halted;

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
// Shared definitions for the single-cycle WISC core
// Word and register widths, opcodes, branch conditions,
// flag and control bundles, and ISA constants
`default_nettype none

package cpu_pkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------
    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [2:0]  cond_t;

    // Register file depth
    localparam int NUM_REGS = 16;

    // ---------------------------------------------------------------------
    // Opcodes, top nibble of every instruction
    // ---------------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_XOR    = 4'd2,
        OP_RED    = 4'd3,
        OP_SLL    = 4'd4,
        OP_SRA    = 4'd5,
        OP_ROR    = 4'd6,
        OP_PADDSB = 4'd7,
        OP_LW     = 4'd8,
        OP_SW     = 4'd9,
        OP_LLB    = 4'd10,
        OP_LHB    = 4'd11,
        OP_B      = 4'd12,
        OP_BR     = 4'd13,
        OP_PCS    = 4'd14,
        OP_HLT    = 4'd15
    } opcode_t;

    // Branch condition codes, instr[11:9] of B and BR
    localparam cond_t COND_NE     = 3'd0;
    localparam cond_t COND_EQ     = 3'd1;
    localparam cond_t COND_GT     = 3'd2;
    localparam cond_t COND_LT     = 3'd3;
    localparam cond_t COND_GE     = 3'd4;
    localparam cond_t COND_LE     = 3'd5;
    localparam cond_t COND_OV     = 3'd6;
    localparam cond_t COND_ALWAYS = 3'd7;

    // ---------------------------------------------------------------------
    // Flags and decoded controls
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic zero;
        logic overflow;
        logic negative;
    } flags_t;

    typedef struct packed {
        logic   reg_write;
        logic   alu_src_imm;
        logic   mem_read;
        logic   mem_write;
        logic   mem_to_reg;
        logic   llb;
        logic   lhb;
        logic   branch;
        logic   branch_reg;
        logic   pcs;
        logic   halt;
        flags_t flag_en;
    } ctrl_t;

    // Flag write masks
    localparam flags_t FLAG_EN_ALL  = '{zero: 1'b1, overflow: 1'b1, negative: 1'b1};
    localparam flags_t FLAG_EN_ZERO = '{zero: 1'b1, overflow: 1'b0, negative: 1'b0};

    // ---------------------------------------------------------------------
    // ISA constants
    // ---------------------------------------------------------------------
    localparam word_t INSTR_STEP      = 16'h0002;
    localparam word_t ADDR_ALIGN_MASK = 16'hFFFE;
    localparam word_t LLB_KEEP_MASK   = 16'hFF00;
    localparam word_t LHB_KEEP_MASK   = 16'h00FF;
    localparam word_t SAT_POS         = 16'h7FFF;
    localparam word_t SAT_NEG         = 16'h8000;

endpackage

`default_nettype wire

// ==== src/pc_control.sv ====
// PC and flag state of the WISC core
// Holds the PC, flag register and halt state, evaluates the
// branch condition and picks the next PC
`default_nettype none

module pc_control (
    input  logic            clk,
    input  logic            reset,
    input  cpu_pkg::ctrl_t  ctrl,
    input  cpu_pkg::cond_t  cond,
    input  cpu_pkg::word_t  branch_offset,
    input  cpu_pkg::word_t  branch_target,
    input  cpu_pkg::flags_t new_flags,
    output cpu_pkg::word_t  pc,
    output cpu_pkg::word_t  pc_plus_two,
    output logic            halted
);

    cpu_pkg::flags_t flags_q;
    cpu_pkg::flags_t flags_next;
    cpu_pkg::word_t  next_pc;
    logic            taken;

    assign pc_plus_two = pc + cpu_pkg::INSTR_STEP;

    // ---------------------------------------------------------------------
    // Branch condition against the stored flags
    // ---------------------------------------------------------------------
    always_comb begin
        case (cond)
            cpu_pkg::COND_NE: taken = ~flags_q.zero;
            cpu_pkg::COND_EQ: taken = flags_q.zero;
            cpu_pkg::COND_GT: taken = ~flags_q.zero & ~flags_q.negative;
            cpu_pkg::COND_LT: taken = flags_q.negative;
            // GE is GT or equal
            cpu_pkg::COND_GE: taken = (~flags_q.zero & ~flags_q.negative) | flags_q.zero;
            cpu_pkg::COND_LE: taken = flags_q.negative | flags_q.zero;
            cpu_pkg::COND_OV: taken = flags_q.overflow;
            default:          taken = 1'b1;
        endcase
    end

    // Next PC, HLT holds the current one
    always_comb begin
        if (ctrl.halt) begin
            next_pc = pc;
        end else if (ctrl.branch && taken) begin
            next_pc = pc_plus_two + branch_offset;
        end else if (ctrl.branch_reg && taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus_two;
        end
    end

    // Per-bit flag update under the write mask
    assign flags_next = cpu_pkg::flags_t'((flags_q & ~ctrl.flag_en) | (new_flags & ctrl.flag_en));

    // ---------------------------------------------------------------------
    // State
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            flags_q <= '0;
            halted  <= 1'b0;
        end else if (!halted) begin
            pc      <= next_pc;
            flags_q <= flags_next;
            if (ctrl.halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
// Register file of the WISC core
// Sixteen 16-bit registers, two combinational read ports and
// one write port; register 0 always reads zero
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t read_addr1,
    input  cpu_pkg::reg_addr_t read_addr2,
    input  cpu_pkg::reg_addr_t write_addr,
    input  logic               write_en,
    input  cpu_pkg::word_t     write_data,
    output cpu_pkg::word_t     read_data1,
    output cpu_pkg::word_t     read_data2
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

    // Write on the edge; register 0 ignores writes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_addr != '0)) begin
            regs[write_addr] <= write_data;
        end
    end

    // No bypass, a write shows up on the next cycle
    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
// Clock and power-on reset source for the testbench
// 20-unit period, reset held high for the first 4 rising edges
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/cpu_chk.sv ====
// Protocol assertions for the WISC core
// Halt behavior, fetch address and PC alignment
`default_nettype none

module cpu_chk (
    input logic           clk,
    input logic           reset,
    input cpu_pkg::word_t pc,
    input cpu_pkg::word_t instr_addr,
    input logic           mem_we,
    input logic           hlt
);

    // No store once halted
    a_no_store_halted: assert property (@(posedge clk) disable iff (reset) hlt |-> !mem_we)
        else $error("mem_we high while hlt is high");

    a_pc_frozen: assert property (@(posedge clk) disable iff (reset) hlt |=> $stable(pc))
        else $error("pc moved while hlt is high");

    a_fetch_addr: assert property (@(posedge clk) disable iff (reset) instr_addr == pc)
        else $error("instr_addr differs from pc");

    // Instructions are word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
        else $error("pc bit 0 set");

endmodule

bind cpu cpu_chk chk (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .instr_addr (instr_addr),
    .mem_we     (mem_we),
    .hlt        (hlt)
);

`default_nettype wire

// ==== tests/cpu_tb.sv ====
// Testbench for the single-cycle WISC core
// Random program from an LFSR, memory models, and an ISA
// reference model checked against the core every cycle
`default_nettype none

module cpu_tb;

    localparam int RUN_CYCLES = 3000;

    logic        clk;
    logic        por;
    logic        restart_req;
    logic        dut_reset;
    logic [15:0] instr_addr;
    logic [15:0] instr;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic        mem_we;
    logic [15:0] mem_rdata;
    logic [15:0] pc;
    logic        hlt;

    logic [15:0] prog [256];
    logic [15:0] dmem [256];

    // Reference model state
    logic [15:0] m_regs [16];
    logic [15:0] m_mem [256];
    logic [15:0] m_pc;
    logic        m_z;
    logic        m_v;
    logic        m_n;
    logic        m_halted;
    logic [31:0] lfsr_state;

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (por)
    );

    assign dut_reset = por | restart_req;

    cpu dut (
        .clk        (clk),
        .reset      (dut_reset),
        .instr_addr (instr_addr),
        .instr      (instr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .mem_rdata  (mem_rdata),
        .pc         (pc),
        .hlt        (hlt)
    );

    // ------------------------------------------------------------------------
    // External memories
    // ------------------------------------------------------------------------
    assign instr     = prog[instr_addr[8:1]];
    assign mem_rdata = dmem[mem_addr[8:1]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[8:1]] <= mem_wdata;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'hA300_0000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR time=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // ISA reference model
    // ------------------------------------------------------------------------
    function automatic logic [16:0] saturate(input int s);
        if (s > 32767) begin
            return {1'b1, 16'h7FFF};
        end else if (s < -32768) begin
            return {1'b1, 16'h8000};
        end
        return {1'b0, s[15:0]};
    endfunction

    function automatic logic [3:0] nibble_sat(input logic [3:0] x, input logic [3:0] y);
        int sx;
        int sy;
        int s;
        sx = x[3] ? int'(x) - 16 : int'(x);
        sy = y[3] ? int'(y) - 16 : int'(y);
        s  = sx + sy;
        if (s > 7) begin
            return 4'h7;
        end else if (s < -8) begin
            return 4'h8;
        end
        return s[3:0];
    endfunction

    function automatic logic cond_holds(input logic [2:0] c);
        case (c)
            3'd0: return !m_z;
            3'd1: return m_z;
            3'd2: return !m_z && !m_n;
            3'd3: return m_n;
            3'd4: return (!m_z && !m_n) || m_z;
            3'd5: return m_n || m_z;
            3'd6: return m_v;
            default: return 1'b1;
        endcase
    endfunction

    task automatic model_reset();
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = '0;
        end
        m_pc     = '0;
        m_z      = 1'b0;
        m_v      = 1'b0;
        m_n      = 1'b0;
        m_halted = 1'b0;
    endtask

    // Compare this cycle's outputs, then retire one instruction in the model
    task automatic execute_and_check();
        logic [15:0] ins;
        logic [15:0] ra;
        logic [15:0] res;
        logic [15:0] nxt;
        logic [15:0] addr;
        logic [16:0] sat;
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic        we_exp;
        logic        wr;
        ins    = prog[m_pc[8:1]];
        op     = ins[15:12];
        rd     = ins[11:8];
        rs     = ins[7:4];
        rt     = ins[3:0];
        ra     = m_regs[rs];
        addr   = (ra & 16'hFFFE) + {{11{rt[3]}}, rt, 1'b0};
        nxt    = m_pc + 16'd2;
        res    = '0;
        we_exp = 1'b0;
        wr     = 1'b0;
        check("pc", pc, m_pc);
        check("instr_addr", instr_addr, m_pc);
        check("hlt", {15'd0, hlt}, {15'd0, m_halted});
        if (m_halted) begin
            nxt = m_pc;
        end else begin
            case (op)
                4'd0, 4'd1: begin
                    if (op == 4'd0) begin
                        sat = saturate(int'($signed(ra)) + int'($signed(m_regs[rt])));
                    end else begin
                        sat = saturate(int'($signed(ra)) - int'($signed(m_regs[rt])));
                    end
                    res = sat[15:0];
                    wr  = 1'b1;
                    m_v = sat[16];
                    m_n = res[15];
                    m_z = (res == 16'd0);
                end
                4'd2, 4'd4, 4'd5, 4'd6: begin
                    res = ra;
                    if (op == 4'd2) begin
                        res = ra ^ m_regs[rt];
                    end
                    for (int k = 0; k < int'(rt) && op != 4'd2; k++) begin
                        if (op == 4'd4) begin
                            res = {res[14:0], 1'b0};
                        end else if (op == 4'd5) begin
                            res = {res[15], res[15:1]};
                        end else begin
                            res = {res[0], res[15:1]};
                        end
                    end
                    wr  = 1'b1;
                    m_z = (res == 16'd0);
                end
                4'd7: begin
                    for (int k = 0; k < 4; k++) begin
                        res[4*k +: 4] = nibble_sat(ra[4*k +: 4], m_regs[rt][4*k +: 4]);
                    end
                    wr = 1'b1;
                end
                4'd8: begin
                    res = m_mem[addr[8:1]];
                    wr  = 1'b1;
                end
                4'd9: begin
                    we_exp = 1'b1;
                end
                4'd10: begin
                    res = (m_regs[rd] & 16'hFF00) | {8'h00, ins[7:0]};
                    wr  = 1'b1;
                end
                4'd11: begin
                    res = (m_regs[rd] & 16'h00FF) | {ins[7:0], 8'h00};
                    wr  = 1'b1;
                end
                4'd12: begin
                    if (cond_holds(ins[11:9])) begin
                        nxt = m_pc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
                    end
                end
                4'd13: begin
                    if (cond_holds(ins[11:9])) begin
                        nxt = ra;
                    end
                end
                4'd14: begin
                    res = m_pc + 16'd2;
                    wr  = 1'b1;
                end
                4'd15: begin
                    nxt      = m_pc;
                    m_halted = 1'b1;
                end
                // RED acts as a no-op
                default: begin
                end
            endcase
        end
        check("mem_we", {15'd0, mem_we}, {15'd0, we_exp});
        if (we_exp) begin
            check("mem_addr", mem_addr, addr);
            check("mem_wdata", mem_wdata, m_regs[rd]);
            m_mem[addr[8:1]] = m_regs[rd];
        end
        if (wr && rd != 4'd0) begin
            m_regs[rd] = res;
        end
        m_pc = nxt;
    endtask

    task automatic run_cycles(input int n);
        for (int i = 0; i < n && !m_halted; i++) begin
            execute_and_check();
            @(negedge clk);
        end
    endtask

    task automatic check_reset_outputs();
        check("pc", pc, 16'd0);
        check("mem_we", {15'd0, mem_we}, 16'd0);
        check("hlt", {15'd0, hlt}, 16'd0);
    endtask

    // ------------------------------------------------------------------------
    // Program and data preset
    // ------------------------------------------------------------------------
    task automatic build_program();
        logic [31:0] v;
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  low;
        for (int a = 0; a < 256; a++) begin
            v   = rand_bits(7);
            // HLT about once in 128 words
            op  = (v == 32'd0) ? 4'd15 : 4'(v % 32'd15);
            v   = rand_bits(4);
            rd  = v[3:0];
            v   = rand_bits(4);
            rs  = v[3:0];
            v   = rand_bits(4);
            low = v[3:0];
            // r15 only ever holds PCS results, so BR targets stay even
            if (op != 4'd14 && rd == 4'd15) begin
                rd = 4'd14;
            end
            if (op == 4'd13) begin
                v  = rand_bits(1);
                rs = v[0] ? 4'd15 : 4'd0;
            end
            prog[a] = {op, rd, rs, low};
        end
        prog[255] = 16'hF000;
        for (int a = 0; a < 256; a++) begin
            v       = rand_bits(16);
            dmem[a] = v[15:0];
            m_mem[a] = v[15:0];
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        restart_req = 1'b0;
        lfsr_state  = 32'd97565;
        build_program();
        model_reset();
        @(negedge clk);
        while (dut_reset) begin
            check_reset_outputs();
            @(negedge clk);
        end
        run_cycles(2800);
        // A program looping short of HLT gets one placed at its next PC
        if (!m_halted) begin
            execute_and_check();
            @(posedge clk);
            prog[m_pc[8:1]] <= 16'hF000;
            @(negedge clk);
            run_cycles(1);
        end
        // Halt must hold
        repeat (4) begin
            execute_and_check();
            @(negedge clk);
        end
        @(posedge clk);
        restart_req <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        restart_req <= 1'b0;
        @(negedge clk);
        model_reset();
        run_cycles(60);
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(20 * (RUN_CYCLES + 10));
        $display("Watchdog expired before the run finished");
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

`default_nettype wire
